// ==== include/lc3b_cfg.svh ====
// 8 registers and an 8-bit byte-addressed APB map; register n sits at REG0 + 4n, word aligned
`ifndef LC3B_CFG_SVH
`define LC3B_CFG_SVH

// register file depth, indices stay 3 bits wide
`define LC3B_NUM_REGS 8

// APB byte address width
`define LC3B_APB_AW 8

// address map
`define LC3B_ADDR_INSTR 8'h00
`define LC3B_ADDR_COUNT 8'h04
`define LC3B_ADDR_CC 8'h08
`define LC3B_ADDR_REG0 8'h20

`endif

// ==== list.f ====
+incdir+include
verilog/lc3b_types.sv
verilog/lc3b_ctrl_pkg.sv
verilog/apb_issue.sv
verilog/control_rom.sv
verilog/decode_stage.sv
verilog/execute_stage.sv
verilog/regfile_wb.sv
verilog/lc3b_alu_pipe.sv
test/tb_lc3b_alu_pipe.sv

// ==== run.sh ====
#!/usr/bin/env bash
# build and run the testbench with Verilator, then look for the pass line in the log

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal \
    --top-module tb_lc3b_alu_pipe -f list.f --Mdir obj_dir -o tb_sim
if [ $? -ne 0 ]; then
    echo "build failed"
    exit 1
fi

./obj_dir/tb_sim > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -q -x -F '** PASS **' sim.log; then
    exit 0
fi
exit 1

// ==== test/tb_lc3b_alu_pipe.sv ====
// random ADD/AND/NOT/SHF streams over APB, checked against an ISA model; fixed seed 32'h9763
`include "lc3b_cfg.svh"

module tb_lc3b_alu_pipe
    import lc3b_types::*;
();

    timeunit 1ns;
    timeprecision 100ps;

    localparam int N_ADD_AND = 200;
    localparam int N_NOT_SHF = 100;
    localparam int N_MIXED   = 100;
    localparam int N_CHAINS  = 4;
    // transfers of all tests together
    localparam int N_XFERS = 10 + (N_ADD_AND + 8) + (N_NOT_SHF + 8) + (2 * N_MIXED + 8) + 1
                           + 4 * N_CHAINS + 15;
    localparam int WATCHDOG_CYCLES = N_XFERS * 10 + 1000;

    logic                    clk;
    logic                    arst_n;
    logic                    psel;
    logic                    penable;
    logic                    pwrite;
    logic [`LC3B_APB_AW-1:0] paddr;
    lc3b_word                pwdata;
    lc3b_word                prdata;
    logic                    pready;
    logic                    pslverr;

    // reference model state
    lc3b_word   model_regs [8];
    logic [2:0] model_cc;
    lc3b_word   model_count;

    int errors;
    int errors_at_start;
    int tests_passed;
    int tests_failed;

    lc3b_alu_pipe lc3b_alu_pipe_inst (
        .clk     (clk),
        .arst_n  (arst_n),
        .psel    (psel),
        .penable (penable),
        .pwrite  (pwrite),
        .paddr   (paddr),
        .pwdata  (pwdata),
        .prdata  (prdata),
        .pready  (pready),
        .pslverr (pslverr)
    );

    initial
    begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    initial
    begin
        repeat (WATCHDOG_CYCLES) @(posedge clk);
        $display("Timeout: the run did not finish within %0d cycles.", WATCHDOG_CYCLES);
        $display("** FAIL **");
        $finish;
    end

    task automatic check_equal(input lc3b_word got, input lc3b_word exp, input string what);
        if (got !== exp)
        begin
            $display("Mismatch at %0t ns: %s read %h, expected %h", $time, what, got, exp);
            errors++;
        end
    endtask

    // setup phase, access phase, then idle; pready and prdata sampled on the rising edge
    task automatic apb_transfer(input logic write, input logic [7:0] addr, input lc3b_word wdata,
                                output lc3b_word rdata, output logic err);
        @(negedge clk);
        psel    = 1'b1;
        penable = 1'b0;
        pwrite  = write;
        paddr   = addr;
        pwdata  = wdata;
        @(negedge clk);
        penable = 1'b1;
        @(posedge clk);
        while (!pready)
            @(posedge clk);
        rdata = prdata;
        err   = pslverr;
        @(negedge clk);
        psel    = 1'b0;
        penable = 1'b0;
    endtask

    // ISA rules: imm5 sign-extended, 16-bit wrap, SHF amount in bits 3..0
    function automatic void model_execute(input lc3b_word instr);
        lc3b_word a;
        lc3b_word b;
        lc3b_word v;
        logic     wrote;
        a     = model_regs[instr[8:6]];
        b     = instr[5] ? lc3b_word'($signed(instr[4:0])) : model_regs[instr[2:0]];
        v     = '0;
        wrote = 1'b1;
        case (instr[15:12])
            4'b0001: v = a + b;
            4'b0101: v = a & b;
            4'b1001: v = ~a;
            4'b1101:
            begin
                v = a;
                if (!instr[4])
                    v = a << instr[3:0];
                else
                    for (int k = 0; k < instr[3:0]; k++)
                        v = {instr[5] ? v[15] : 1'b0, v[15:1]};
            end
            default: wrote = 1'b0;
        endcase
        model_count = model_count + 16'd1;
        if (wrote)
        begin
            model_regs[instr[11:9]] = v;
            if (v == '0)
                model_cc = 3'b010;
            else if (v[15])
                model_cc = 3'b100;
            else
                model_cc = 3'b001;
        end
    endfunction

    task automatic write_instr(input lc3b_word instr);
        lc3b_word unused;
        logic     err;
        apb_transfer(1'b1, `LC3B_ADDR_INSTR, instr, unused, err);
        if (err)
        begin
            $display("The instruction write at %0t ns was refused with pslverr.", $time);
            errors++;
        end
        model_execute(instr);
    endtask

    task automatic read_and_compare(input logic [7:0] addr, input lc3b_word exp,
                                    input string what);
        lc3b_word data;
        logic     err;
        apb_transfer(1'b0, addr, '0, data, err);
        if (err)
        begin
            $display("The read of %s at %0t ns ended with pslverr on a valid address.", what, $time);
            errors++;
        end
        check_equal(data, exp, what);
    endtask

    task automatic check_state();
        for (int r = 0; r < 8; r++)
            read_and_compare(8'(`LC3B_ADDR_REG0 + 4 * r), model_regs[r], $sformatf("R%0d", r));
    endtask

    task automatic expect_slverr(input logic write, input logic [7:0] addr);
        lc3b_word data;
        logic     err;
        apb_transfer(write, addr, 16'hbeef, data, err);
        if (!err)
        begin
            $display("An access to unmapped address %h completed without pslverr.", addr);
            errors++;
        end
    endtask

    task automatic finish_test(input string name);
        if (errors == errors_at_start)
        begin
            tests_passed++;
            $display("test %s: passed", name);
        end
        else
        begin
            tests_failed++;
            $display("test %s: failed with %0d errors", name, errors - errors_at_start);
        end
        errors_at_start = errors;
    endtask

    function automatic lc3b_word make_add_and();
        lc3b_word w;
        w = 16'($urandom);
        w[15:12] = ($urandom_range(0, 1) == 0) ? op_add : op_and;
        if (!w[5])
            w[4:3] = 2'b00;
        return w;
    endfunction

    function automatic lc3b_word make_not_shf();
        lc3b_word w;
        w = 16'($urandom);
        w[15:12] = ($urandom_range(0, 1) == 0) ? op_not : op_shf;
        if (w[15:12] == op_not)
            w[5:0] = 6'h3f;
        return w;
    endfunction

    // half kept opcodes, half any opcode at all
    function automatic lc3b_word make_any();
        if ($urandom_range(0, 1) == 0)
            return ($urandom_range(0, 1) == 0) ? make_add_and() : make_not_shf();
        return 16'($urandom);
    endfunction

    initial
    begin
        logic [2:0] d;
        logic [2:0] s;
        psel    = 1'b0;
        penable = 1'b0;
        pwrite  = 1'b0;
        paddr   = '0;
        pwdata  = '0;
        arst_n  = 1'b0;
        void'($urandom(32'h9763));
        for (int r = 0; r < 8; r++)
            model_regs[r] = '0;
        model_cc        = 3'b000;
        model_count     = '0;
        errors          = 0;
        errors_at_start = 0;
        tests_passed    = 0;
        tests_failed    = 0;
        repeat (10) @(posedge clk);
        @(negedge clk);
        arst_n = 1'b1;

        check_state();
        read_and_compare(`LC3B_ADDR_CC, '0, "cc");
        read_and_compare(`LC3B_ADDR_COUNT, '0, "retire count");
        finish_test("reset values");

        repeat (N_ADD_AND) write_instr(make_add_and());
        check_state();
        finish_test("add and");

        repeat (N_NOT_SHF) write_instr(make_not_shf());
        check_state();
        finish_test("not shf");

        repeat (N_MIXED)
        begin
            write_instr(make_any());
            read_and_compare(`LC3B_ADDR_CC, {13'b0, model_cc}, "cc");
        end
        check_state();
        finish_test("condition codes");

        read_and_compare(`LC3B_ADDR_COUNT, model_count, "retire count");
        finish_test("retire count");

        // each instruction reads the result of the one before it
        for (int c = 0; c < N_CHAINS; c++)
        begin
            d = 3'($urandom);
            s = 3'($urandom);
            write_instr({op_add, d, s, 1'b1, 5'($urandom)});
            write_instr({op_shf, d, d, 1'b0, 1'b0, 4'd1});
            write_instr({op_add, d, d, 1'b0, 2'b00, s});
            read_and_compare(8'(`LC3B_ADDR_REG0 + 4 * d), model_regs[d], "chain result");
        end
        finish_test("read stall");

        expect_slverr(1'b1, `LC3B_ADDR_COUNT);
        expect_slverr(1'b1, 8'h0c);
        expect_slverr(1'b0, 8'h10);
        expect_slverr(1'b0, 8'h22);
        expect_slverr(1'b0, 8'h40);
        check_state();
        read_and_compare(`LC3B_ADDR_CC, {13'b0, model_cc}, "cc");
        read_and_compare(`LC3B_ADDR_COUNT, model_count, "retire count");
        finish_test("unmapped access");

        $display("%0d tests passed, %0d tests failed", tests_passed, tests_failed);
        if (tests_failed == 0 && errors == 0)
            $display("** PASS **");
        else
            $display("** FAIL **");
        $finish;
    end

endmodule : tb_lc3b_alu_pipe

// ==== verilog/apb_issue.sv ====
// APB slave without wait states on writes; reads stall until the pipeline is empty
`include "lc3b_cfg.svh"

module apb_issue
    import lc3b_types::*;
(
    input  logic                      clk,
    input  logic                      arst_n,
    input  logic                      psel,
    input  logic                      penable,
    input  logic                      pwrite,
    input  logic [`LC3B_APB_AW-1:0]   paddr,
    input  lc3b_word                  pwdata,
    output lc3b_word                  prdata,
    output logic                      pready,
    output logic                      pslverr,
    input  logic                      inflight,
    output logic                      issue_valid,
    output lc3b_instr                 issue_instr,
    output logic [2:0]                host_idx,
    input  lc3b_word                  host_rdata,
    input  logic [2:0]                cc_nzp,
    input  lc3b_word                  retire_count
);

    logic                    access;
    logic                    hit_instr;
    logic                    hit_count;
    logic                    hit_cc;
    logic                    hit_reg;
    logic [`LC3B_APB_AW-1:0] reg_offset;

    assign access    = psel && penable;
    assign hit_instr = (paddr == `LC3B_ADDR_INSTR);
    assign hit_count = (paddr == `LC3B_ADDR_COUNT);
    assign hit_cc    = (paddr == `LC3B_ADDR_CC);

    // register window, word aligned
    assign reg_offset = paddr - `LC3B_ADDR_REG0;
    assign hit_reg    = (paddr >= `LC3B_ADDR_REG0)
                     && (reg_offset < 4 * `LC3B_NUM_REGS)
                     && (paddr[1:0] == 2'b00);
    assign host_idx   = reg_offset[4:2];

    // writes finish at once, reads wait for every earlier instruction to retire
    assign pready  = access && (pwrite || !inflight);
    assign pslverr = pready && (pwrite ? !hit_instr : !(hit_count || hit_cc || hit_reg));

    always_comb
    begin
        prdata = '0;
        if (hit_count)
            prdata = retire_count;
        else if (hit_cc)
            prdata = {13'b0, cc_nzp};
        else if (hit_reg)
            prdata = host_rdata;
    end

    always_ff @(posedge clk or negedge arst_n)
    begin
        if (!arst_n)
            issue_valid <= 1'b0;
        else
            issue_valid <= access && pwrite && hit_instr;
    end

    always_ff @(posedge clk)
    begin
        if (access && pwrite && hit_instr)
            issue_instr <= pwdata;
    end

    // the two-cycle APB transfer limits issue to every other cycle
    a_issue_single: assert property (@(posedge clk) disable iff (!arst_n)
        issue_valid |=> !issue_valid);

endmodule : apb_issue

// ==== verilog/control_rom.sv ====
// pure decode of ADD, AND, NOT and SHF; any other opcode yields the all-zero word
module control_rom
    import lc3b_types::*, lc3b_ctrl_pkg::*;
(
    input  lc3b_opcode        opcode,
    input  logic              ir5,
    input  logic              ir4,
    output lc3b_control_word  ctrl
);

    always_comb
    begin
        ctrl = '0;

        case (opcode)
            op_add:
            begin
                ctrl.aluop      = alu_add;
                ctrl.sr2mux_sel = ir5;
                ctrl.load_reg   = 1'b1;
                ctrl.load_cc    = 1'b1;
            end

            op_and:
            begin
                ctrl.aluop      = alu_and;
                ctrl.sr2mux_sel = ir5;
                ctrl.load_reg   = 1'b1;
                ctrl.load_cc    = 1'b1;
            end

            op_not:
            begin
                ctrl.aluop    = alu_not;
                ctrl.load_reg = 1'b1;
                ctrl.load_cc  = 1'b1;
            end

            op_shf:
            begin
                // ir4 picks the direction, ir5 the sign fill on right shifts
                if (!ir4)
                    ctrl.aluop = alu_sll;
                else if (ir5)
                    ctrl.aluop = alu_sra;
                else
                    ctrl.aluop = alu_srl;
                ctrl.load_reg = 1'b1;
                ctrl.load_cc  = 1'b1;
            end

            default:
            begin
                ctrl = '0;
            end
        endcase
    end

endmodule : control_rom

// ==== verilog/decode_stage.sv ====
// one register stage; payload is captured only on an issued instruction
module decode_stage
    import lc3b_types::*, lc3b_ctrl_pkg::*;
(
    input  logic              clk,
    input  logic              arst_n,
    input  logic              issue_valid,
    input  lc3b_instr         issue_instr,
    output logic              dec_valid,
    output lc3b_instr         dec_instr,
    output lc3b_control_word  dec_ctrl
);

    lc3b_control_word rom_ctrl;

    control_rom control_rom_inst (
        .opcode (issue_instr.i.opcode),
        .ir5    (issue_instr.i.mode),
        .ir4    (issue_instr.i.imm5[4]),
        .ctrl   (rom_ctrl)
    );

    always_ff @(posedge clk or negedge arst_n)
    begin
        if (!arst_n)
            dec_valid <= 1'b0;
        else
            dec_valid <= issue_valid;
    end

    always_ff @(posedge clk)
    begin
        if (issue_valid)
        begin
            dec_instr <= issue_instr;
            dec_ctrl  <= rom_ctrl;
        end
    end

    // unsupported opcodes must retire without side effects
    a_noop_ctrl: assert property (@(posedge clk) disable iff (!arst_n)
        dec_valid && !(dec_instr.i.opcode inside {op_add, op_and, op_not, op_shf})
        |-> dec_ctrl == '0);

endmodule : decode_stage

// ==== verilog/execute_stage.sv ====
// register file is read combinationally here; no forwarding, the issue rate covers hazards
module execute_stage
    import lc3b_types::*, lc3b_ctrl_pkg::*;
(
    input  logic              clk,
    input  logic              arst_n,
    input  logic              dec_valid,
    input  lc3b_instr         dec_instr,
    input  lc3b_control_word  dec_ctrl,
    output logic [2:0]        rf_idx1,
    output logic [2:0]        rf_idx2,
    input  lc3b_word          rf_rdata1,
    input  lc3b_word          rf_rdata2,
    output logic              ex_valid,
    output logic              ex_load_reg,
    output logic              ex_load_cc,
    output logic [2:0]        ex_dr,
    output lc3b_word          ex_result
);

    lc3b_word   imm_sext;
    lc3b_word   opb;
    logic [3:0] shamt;
    lc3b_word   result;

    assign rf_idx1 = dec_instr.r.sr1;
    assign rf_idx2 = dec_instr.r.sr2;

    assign imm_sext = {{11{dec_instr.i.imm5[4]}}, dec_instr.i.imm5};
    assign opb      = dec_ctrl.sr2mux_sel ? imm_sext : rf_rdata2;
    assign shamt    = dec_instr.i.imm5[3:0];

    always_comb
    begin
        case (dec_ctrl.aluop)
            alu_add:  result = rf_rdata1 + opb;
            alu_and:  result = rf_rdata1 & opb;
            alu_not:  result = ~rf_rdata1;
            alu_sll:  result = rf_rdata1 << shamt;
            alu_srl:  result = rf_rdata1 >> shamt;
            // arithmetic shift keeps the sign bit
            alu_sra:  result = lc3b_word'($signed(rf_rdata1) >>> shamt);
            default:  result = '0;
        endcase
    end

    always_ff @(posedge clk or negedge arst_n)
    begin
        if (!arst_n)
        begin
            ex_valid    <= 1'b0;
            ex_load_reg <= 1'b0;
            ex_load_cc  <= 1'b0;
        end
        else
        begin
            ex_valid    <= dec_valid;
            ex_load_reg <= dec_valid && dec_ctrl.load_reg;
            ex_load_cc  <= dec_valid && dec_ctrl.load_cc;
        end
    end

    always_ff @(posedge clk)
    begin
        if (dec_valid)
        begin
            ex_dr     <= dec_instr.r.dr;
            ex_result <= result;
        end
    end

endmodule : execute_stage

// ==== verilog/lc3b_alu_pipe.sv ====
// three-stage ADD/AND/NOT/SHF pipeline behind APB; no memory, no PC, no branches
`include "lc3b_cfg.svh"

module lc3b_alu_pipe
    import lc3b_types::*, lc3b_ctrl_pkg::*;
(
    input  logic                      clk,
    input  logic                      arst_n,
    input  logic                      psel,
    input  logic                      penable,
    input  logic                      pwrite,
    input  logic [`LC3B_APB_AW-1:0]   paddr,
    input  lc3b_word                  pwdata,
    output lc3b_word                  prdata,
    output logic                      pready,
    output logic                      pslverr
);

    logic             inflight;
    logic             issue_valid;
    lc3b_instr        issue_instr;
    logic [2:0]       host_idx;
    lc3b_word         host_rdata;
    logic [2:0]       cc_nzp;
    lc3b_word         retire_count;
    logic             dec_valid;
    lc3b_instr        dec_instr;
    lc3b_control_word dec_ctrl;
    logic [2:0]       rf_idx1;
    logic [2:0]       rf_idx2;
    lc3b_word         rf_rdata1;
    lc3b_word         rf_rdata2;
    logic             ex_valid;
    logic             ex_load_reg;
    logic             ex_load_cc;
    logic [2:0]       ex_dr;
    lc3b_word         ex_result;

    // host reads hold off while either stage is busy
    assign inflight = dec_valid || ex_valid;

    apb_issue apb_issue_inst (
        .clk          (clk),
        .arst_n       (arst_n),
        .psel         (psel),
        .penable      (penable),
        .pwrite       (pwrite),
        .paddr        (paddr),
        .pwdata       (pwdata),
        .prdata       (prdata),
        .pready       (pready),
        .pslverr      (pslverr),
        .inflight     (inflight),
        .issue_valid  (issue_valid),
        .issue_instr  (issue_instr),
        .host_idx     (host_idx),
        .host_rdata   (host_rdata),
        .cc_nzp       (cc_nzp),
        .retire_count (retire_count)
    );

    decode_stage decode_stage_inst (
        .clk         (clk),
        .arst_n      (arst_n),
        .issue_valid (issue_valid),
        .issue_instr (issue_instr),
        .dec_valid   (dec_valid),
        .dec_instr   (dec_instr),
        .dec_ctrl    (dec_ctrl)
    );

    execute_stage execute_stage_inst (
        .clk         (clk),
        .arst_n      (arst_n),
        .dec_valid   (dec_valid),
        .dec_instr   (dec_instr),
        .dec_ctrl    (dec_ctrl),
        .rf_idx1     (rf_idx1),
        .rf_idx2     (rf_idx2),
        .rf_rdata1   (rf_rdata1),
        .rf_rdata2   (rf_rdata2),
        .ex_valid    (ex_valid),
        .ex_load_reg (ex_load_reg),
        .ex_load_cc  (ex_load_cc),
        .ex_dr       (ex_dr),
        .ex_result   (ex_result)
    );

    regfile_wb regfile_wb_inst (
        .clk          (clk),
        .arst_n       (arst_n),
        .ex_valid     (ex_valid),
        .ex_load_reg  (ex_load_reg),
        .ex_load_cc   (ex_load_cc),
        .ex_dr        (ex_dr),
        .ex_result    (ex_result),
        .rf_idx1      (rf_idx1),
        .rf_idx2      (rf_idx2),
        .host_idx     (host_idx),
        .rf_rdata1    (rf_rdata1),
        .rf_rdata2    (rf_rdata2),
        .host_rdata   (host_rdata),
        .cc_nzp       (cc_nzp),
        .retire_count (retire_count)
    );

endmodule : lc3b_alu_pipe

// ==== verilog/lc3b_ctrl_pkg.sv ====
// control word for the ALU-only datapath; no memory, branch or PC fields exist here
package lc3b_ctrl_pkg;

    // shift operations live in aluop, no separate result mux
    typedef enum logic [2:0] {
        alu_add  = 3'd0,
        alu_and  = 3'd1,
        alu_not  = 3'd2,
        alu_sll  = 3'd3,
        alu_srl  = 3'd4,
        alu_sra  = 3'd5,
        alu_pass = 3'd6
    } lc3b_aluop;

    // all-zero word is a no-op: nothing is loaded
    typedef struct packed {
        lc3b_aluop aluop;
        // operand b from the sign-extended imm5
        logic      sr2mux_sel;
        logic      load_reg;
        logic      load_cc;
    } lc3b_control_word;

endpackage : lc3b_ctrl_pkg

// ==== verilog/lc3b_types.sv ====
// LC-3b ISA types only; the SHF form reuses the immediate view of the instruction word
package lc3b_types;

    typedef logic [15:0] lc3b_word;

    typedef enum logic [3:0] {
        op_br   = 4'b0000,
        op_add  = 4'b0001,
        op_ldb  = 4'b0010,
        op_stb  = 4'b0011,
        op_jsr  = 4'b0100,
        op_and  = 4'b0101,
        op_ldr  = 4'b0110,
        op_str  = 4'b0111,
        op_rti  = 4'b1000,
        op_not  = 4'b1001,
        op_ldi  = 4'b1010,
        op_sti  = 4'b1011,
        op_jmp  = 4'b1100,
        op_shf  = 4'b1101,
        op_lea  = 4'b1110,
        op_trap = 4'b1111
    } lc3b_opcode;

    // register form of ADD/AND, sr2 in the low bits
    typedef struct packed {
        lc3b_opcode opcode;
        logic [2:0] dr;
        logic [2:0] sr1;
        logic       mode;
        logic [1:0] zero;
        logic [2:0] sr2;
    } lc3b_instr_reg;

    // immediate form; for SHF mode is the arithmetic flag, imm5[4] the direction
    typedef struct packed {
        lc3b_opcode opcode;
        logic [2:0] dr;
        logic [2:0] sr1;
        logic       mode;
        logic [4:0] imm5;
    } lc3b_instr_imm;

    typedef union packed {
        lc3b_instr_reg r;
        lc3b_instr_imm i;
    } lc3b_instr;

endpackage : lc3b_types

// ==== verilog/regfile_wb.sv ====
// writeback owns all architectural state; reads are combinational, counter wraps at 16 bits
`include "lc3b_cfg.svh"

module regfile_wb
    import lc3b_types::*;
(
    input  logic        clk,
    input  logic        arst_n,
    input  logic        ex_valid,
    input  logic        ex_load_reg,
    input  logic        ex_load_cc,
    input  logic [2:0]  ex_dr,
    input  lc3b_word    ex_result,
    input  logic [2:0]  rf_idx1,
    input  logic [2:0]  rf_idx2,
    input  logic [2:0]  host_idx,
    output lc3b_word    rf_rdata1,
    output lc3b_word    rf_rdata2,
    output lc3b_word    host_rdata,
    output logic [2:0]  cc_nzp,
    output lc3b_word    retire_count
);

    lc3b_word   regs [`LC3B_NUM_REGS];
    logic [2:0] nzp_next;

    assign rf_rdata1  = regs[rf_idx1];
    assign rf_rdata2  = regs[rf_idx2];
    assign host_rdata = regs[host_idx];

    // n, z, p from the sign and zero test
    assign nzp_next[2] = ex_result[15];
    assign nzp_next[1] = (ex_result == '0);
    assign nzp_next[0] = !ex_result[15] && (ex_result != '0);

    always_ff @(posedge clk or negedge arst_n)
    begin
        if (!arst_n)
        begin
            for (int i = 0; i < `LC3B_NUM_REGS; i++)
                regs[i] <= '0;
            cc_nzp       <= 3'b000;
            retire_count <= '0;
        end
        else if (ex_valid)
        begin
            // no-ops retire too
            retire_count <= retire_count + 16'd1;
            if (ex_load_reg)
                regs[ex_dr] <= ex_result;
            if (ex_load_cc)
                cc_nzp <= nzp_next;
        end
    end

    a_cc_onehot: assert property (@(posedge clk) disable iff (!arst_n)
        $onehot0(cc_nzp));

endmodule : regfile_wb
